//--- tests/mac_tx_golden.txt
// type len fcs_mode smd fra ipg ready_hold seed crc_residue
// residue is the reflected crc register over dst mac to the end of the restored fcs
0800 002E 1 D5 00 0C 00 00000001 DEBB20E3
0800 002E 0 D5 00 0C 00 00000001 DEBB20E3
88B5 0040 1 61 E6 0C 00 00000002 DEBB20E3
0806 001C 1 D5 00 0C 05 00000003 DEBB20E3
86DD 0010 1 D5 00 40 00 00000004 DEBB20E3
88B5 0020 1 52 4C 14 08 00000005 DEBB20E3
0800 0001 0 D5 00 0C 00 00000006 DEBB20E3
0800 05DC 1 D5 00 0C 00 00000007 DEBB20E3

//--- mac_tx.f
verilog/mac_tx_pkg.sv
verilog/mac_tx_fcs.sv
verilog/mac_tx_payload_buffer.sv
verilog/mac_tx_header_regs.sv
verilog/mac_tx_framer.sv
verilog/mac_tx.sv
tests/mac_tx_tb.sv

//--- Bender.yml
package:
  name: mac_tx

sources:
  - verilog/mac_tx_pkg.sv
  - verilog/mac_tx_fcs.sv
  - verilog/mac_tx_payload_buffer.sv
  - verilog/mac_tx_header_regs.sv
  - verilog/mac_tx_framer.sv
  - verilog/mac_tx.sv
  - target: test
    files:
      - tests/mac_tx_tb.sv

//--- tests/mac_tx_tb.sv
`timescale 1ns/100ps

module mac_tx_tb
    import mac_tx_pkg::*;
();

    localparam int        CLK_PERIOD = 4;
    localparam int        NUM_LINES  = 8;
    localparam int        NUM_FIELDS = 9;
    localparam mac_addr_t DST_MAC    = 48'h02_11_22_33_44_55;
    localparam mac_addr_t SRC_MAC    = 48'h02_AA_BB_CC_DD_EE;

    logic        i_clk;
    logic        i_rst;
    byte_t       i_send_data;
    logic        i_send_valid;
    logic        i_send_last;
    logic [15:0] i_send_type;
    logic        i_fcs_mode;
    mac_addr_t   i_dst_mac;
    logic        i_dst_mac_valid;
    mac_addr_t   i_src_mac;
    logic        i_src_mac_valid;
    byte_t       i_smd;
    logic        i_smd_valid;
    byte_t       i_fra;
    logic        i_fra_valid;
    byte_t       i_ipg;
    logic        i_ipg_valid;
    logic        i_mac_ready;
    logic        o_send_ready;
    tx_byte_t    o_tx;
    logic        o_busy;
    logic [15:0] o_frames_cnt;
    logic [15:0] o_fragment_cnt;

    logic [31:0] gold [NUM_LINES*NUM_FIELDS];
    byte_t       payload_q [$];
    byte_t       exp_q [$];
    byte_t       cap_q [$];
    logic        last_q [$];
    int          frames_seen = 0;
    int          idle_cnt = 0;
    int          frag_exp = 0;
    logic        in_frame = 1'b0;
    byte_t       cur_ipg = DEFAULT_IPG;
    longint      limit_cycles = 0;
    logic [31:0] lcg_state = 32'd85189;

    mac_tx uut (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        if (exp_val !== act_val)
        begin
            $display("error %s expected %0h actual %0h", name, exp_val, act_val);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] bit_reverse(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++)
        begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    // msb-first register with each byte fed lsb first as on the wire
    function automatic logic [31:0] crc_step(input logic [31:0] c_in, input byte_t b);
        logic [31:0] c;
        c = c_in;
        for (int i = 0; i < 8; i++)
        begin
            c = (c[31] ^ b[i]) ? ((c << 1) ^ 32'h04C1_1DB7) : (c << 1);
        end
        return c;
    endfunction

    //////////////////////////////
    // frame capture
    //////////////////////////////

    always @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            if (o_tx.valid)
            begin
                if (!in_frame && frames_seen > 0)
                begin
                    check($sformatf("idle cycles before frame %0d", frames_seen), cur_ipg,
                          (idle_cnt >= cur_ipg) ? cur_ipg : idle_cnt);
                end
                check("busy while sending", 1'b1, o_busy);
                in_frame = 1'b1;
                cap_q.push_back(o_tx.data);
                last_q.push_back(o_tx.last);
                if (o_tx.last)
                begin
                    in_frame = 1'b0;
                    idle_cnt = 0;
                    frames_seen++;
                end
            end
            else
            begin
                // valid must not drop inside a frame
                check("valid gap inside frame", 1'b0, in_frame);
                idle_cnt++;
            end
        end
    end

    task automatic run_frame(input int n);
        logic [15:0] f_type;
        int          f_len;
        logic        f_mode;
        byte_t       f_smd;
        byte_t       f_fra;
        byte_t       f_ipg;
        int          f_hold;
        logic [31:0] f_resid;
        mac_addr_t   dst;
        logic [31:0] crc;
        byte_t       fcs_b;
        f_type  = gold[n*NUM_FIELDS][15:0];
        f_len   = gold[n*NUM_FIELDS+1];
        f_mode  = gold[n*NUM_FIELDS+2][0];
        f_smd   = gold[n*NUM_FIELDS+3][7:0];
        f_fra   = gold[n*NUM_FIELDS+4][7:0];
        f_ipg   = gold[n*NUM_FIELDS+5][7:0];
        f_hold  = gold[n*NUM_FIELDS+6];
        f_resid = gold[n*NUM_FIELDS+8];

        payload_q.delete();
        exp_q.delete();
        cap_q.delete();
        last_q.delete();
        lcg_state = 32'd85189 ^ gold[n*NUM_FIELDS+7];
        for (int b = 0; b < f_len; b++)
        begin
            lcg_state = lcg_next(lcg_state);
            payload_q.push_back(lcg_state[23:16]);
        end

        // expected wire bytes
        repeat (PREAMBLE_LEN) exp_q.push_back(8'h55);
        if (f_smd inside {SMD_C0, SMD_C1, SMD_C2, SMD_C3})
        begin
            exp_q.push_back(f_smd);
            exp_q.push_back(f_fra);
            frag_exp++;
        end
        else
        begin
            exp_q.push_back(8'h55);
            exp_q.push_back(f_smd);
        end
        dst = (f_type == 16'h0806) ? '1 : DST_MAC;
        for (int k = 5; k >= 0; k--)
        begin
            exp_q.push_back(dst[k*8 +: 8]);
        end
        for (int k = 5; k >= 0; k--)
        begin
            exp_q.push_back(SRC_MAC[k*8 +: 8]);
        end
        exp_q.push_back(f_type[15:8]);
        exp_q.push_back(f_type[7:0]);
        foreach (payload_q[k]) exp_q.push_back(payload_q[k]);
        crc = '1;
        for (int k = FCS_START_IDX; k < exp_q.size(); k++)
        begin
            crc = crc_step(crc, exp_q[k]);
        end
        crc = ~bit_reverse(crc);
        for (int k = 0; k < 4; k++)
        begin
            fcs_b = crc[k*8 +: 8];
            exp_q.push_back((!f_mode && k >= 2) ? ~fcs_b : fcs_b);
        end

        // the first frame runs on the reset gap
        cur_ipg = f_ipg;
        i_ipg       = f_ipg;
        i_ipg_valid = (n > 0);
        i_smd       = f_smd;
        i_smd_valid = 1'b1;
        i_fra       = f_fra;
        i_fra_valid = 1'b1;
        @(negedge i_clk);
        i_ipg_valid = 1'b0;
        i_smd_valid = 1'b0;
        i_fra_valid = 1'b0;
        check("send ready before payload", 1'b1, o_send_ready);

        i_mac_ready = (f_hold == 0);
        i_send_type = f_type;
        i_fcs_mode  = f_mode;
        for (int b = 0; b < f_len; b++)
        begin
            i_send_data  = payload_q[b];
            i_send_valid = 1'b1;
            i_send_last  = (b == f_len - 1);
            @(negedge i_clk);
            check("send ready during payload", 1'b0, o_send_ready);
        end
        i_send_valid = 1'b0;
        i_send_last  = 1'b0;
        repeat (f_hold)
        begin
            check("frame start while mac not ready", 1'b0, o_tx.valid);
            check("send ready while frame pending", 1'b0, o_send_ready);
            @(negedge i_clk);
        end
        i_mac_ready = 1'b1;

        while (frames_seen < n + 1) @(negedge i_clk);

        check($sformatf("frame %0d length", n), exp_q.size(), cap_q.size());
        foreach (exp_q[k])
        begin
            check($sformatf("frame %0d byte %0d", n, k), exp_q[k], cap_q[k]);
            check($sformatf("frame %0d last %0d", n, k), k == exp_q.size() - 1, last_q[k]);
        end
        // receiver view with the mcrc bytes flipped back
        crc = '1;
        for (int k = FCS_START_IDX; k < cap_q.size(); k++)
        begin
            fcs_b = cap_q[k];
            if (!f_mode && k >= cap_q.size() - 2)
            begin
                fcs_b = ~fcs_b;
            end
            crc = crc_step(crc, fcs_b);
        end
        check($sformatf("frame %0d crc residue", n), f_resid, bit_reverse(crc));
        check($sformatf("frame %0d frames count", n), n + 1, o_frames_cnt);
        check($sformatf("frame %0d fragment count", n), frag_exp, o_fragment_cnt);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        i_rst           = 1'b1;
        i_send_data     = '0;
        i_send_valid    = 1'b0;
        i_send_last     = 1'b0;
        i_send_type     = '0;
        i_fcs_mode      = 1'b1;
        i_dst_mac       = '0;
        i_dst_mac_valid = 1'b0;
        i_src_mac       = '0;
        i_src_mac_valid = 1'b0;
        i_smd           = '0;
        i_smd_valid     = 1'b0;
        i_fra           = '0;
        i_fra_valid     = 1'b0;
        i_ipg           = '0;
        i_ipg_valid     = 1'b0;
        i_mac_ready     = 1'b1;
        $readmemh("tests/mac_tx_golden.txt", gold);

        // twice the frame, load, hold and gap cycles
        for (int n = 0; n < NUM_LINES; n++)
        begin
            limit_cycles += 2 * (HDR_LEN + FCS_LEN + 2 * gold[n*NUM_FIELDS+1]
                                 + gold[n*NUM_FIELDS+5] + gold[n*NUM_FIELDS+6] + 8);
        end
        limit_cycles += 64;

        repeat (8) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        check("valid after reset", 1'b0, o_tx.valid);
        check("busy after reset", 1'b0, o_busy);
        check("frames count after reset", 0, o_frames_cnt);
        check("fragment count after reset", 0, o_fragment_cnt);
        check("send ready after reset", 1'b1, o_send_ready);

        i_dst_mac       = DST_MAC;
        i_dst_mac_valid = 1'b1;
        i_src_mac       = SRC_MAC;
        i_src_mac_valid = 1'b1;
        @(negedge i_clk);
        i_dst_mac_valid = 1'b0;
        i_src_mac_valid = 1'b0;

        for (int n = 0; n < NUM_LINES; n++)
        begin
            run_frame(n);
        end
        $display("NO ERRORS");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (limit_cycles != 0);
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog expired before the last frame was checked");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

endmodule

//--- verilog/mac_tx.sv
`timescale 1ns/100ps

module mac_tx
    import mac_tx_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    // payload in
    input  byte_t       i_send_data,
    input  logic        i_send_valid,
    input  logic        i_send_last,
    input  logic [15:0] i_send_type,
    input  logic        i_fcs_mode,
    output logic        o_send_ready,
    // frame settings
    input  mac_addr_t   i_dst_mac,
    input  logic        i_dst_mac_valid,
    input  mac_addr_t   i_src_mac,
    input  logic        i_src_mac_valid,
    input  byte_t       i_smd,
    input  logic        i_smd_valid,
    input  byte_t       i_fra,
    input  logic        i_fra_valid,
    input  byte_t       i_ipg,
    input  logic        i_ipg_valid,
    // byte stream out
    input  logic        i_mac_ready,
    output tx_byte_t    o_tx,
    output logic        o_busy,
    output logic [15:0] o_frames_cnt,
    output logic [15:0] o_fragment_cnt
);

    byte_t            rd_data;
    logic             rd;
    logic             frame_stored;
    logic [LEN_W-1:0] payload_len;
    logic [LEN_W-1:0] byte_idx;
    frame_hdr_t       hdr;
    byte_t            hdr_byte;
    byte_t            ipg;

    mac_tx_payload_buffer u_payload_buffer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_send_data    (i_send_data),
        .i_send_valid   (i_send_valid),
        .i_send_last    (i_send_last),
        .i_rd           (rd),
        .o_rd_data      (rd_data),
        .o_frame_stored (frame_stored),
        .o_payload_len  (payload_len),
        .o_send_ready   (o_send_ready)
    );

    mac_tx_header_regs u_header_regs (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_dst_mac       (i_dst_mac),
        .i_dst_mac_valid (i_dst_mac_valid),
        .i_src_mac       (i_src_mac),
        .i_src_mac_valid (i_src_mac_valid),
        .i_smd           (i_smd),
        .i_smd_valid     (i_smd_valid),
        .i_fra           (i_fra),
        .i_fra_valid     (i_fra_valid),
        .i_ipg           (i_ipg),
        .i_ipg_valid     (i_ipg_valid),
        .i_send_type     (i_send_type),
        .i_fcs_mode      (i_fcs_mode),
        .i_send_valid    (i_send_valid),
        .i_send_last     (i_send_last),
        .i_byte_idx      (byte_idx),
        .o_hdr           (hdr),
        .o_hdr_byte      (hdr_byte),
        .o_ipg           (ipg)
    );

    mac_tx_framer u_framer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_frame_stored (frame_stored),
        .i_payload_len  (payload_len),
        .i_rd_data      (rd_data),
        .i_hdr          (hdr),
        .i_hdr_byte     (hdr_byte),
        .i_ipg          (ipg),
        .i_mac_ready    (i_mac_ready),
        .o_rd           (rd),
        .o_byte_idx     (byte_idx),
        .o_tx           (o_tx),
        .o_busy         (o_busy),
        .o_frames_cnt   (o_frames_cnt),
        .o_fragment_cnt (o_fragment_cnt)
    );

endmodule

//--- verilog/mac_tx_framer.sv
`timescale 1ns/100ps

module mac_tx_framer
    import mac_tx_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_frame_stored,
    input  logic [LEN_W-1:0] i_payload_len,
    input  byte_t            i_rd_data,
    input  frame_hdr_t       i_hdr,
    input  byte_t            i_hdr_byte,
    input  byte_t            i_ipg,
    input  logic             i_mac_ready,
    output logic             o_rd,
    output logic [LEN_W-1:0] o_byte_idx,
    output tx_byte_t         o_tx,
    output logic             o_busy,
    output logic [15:0]      o_frames_cnt,
    output logic [15:0]      o_fragment_cnt
);

    logic             active;
    logic [LEN_W-1:0] idx;
    logic [LEN_W-1:0] len_q;
    logic             fcs_mode_q;
    logic [7:0]       gap_cnt;
    logic             gap_done;
    logic             start;
    logic [LEN_W-1:0] pay_end;
    logic [LEN_W-1:0] last_idx;
    logic             in_payload;
    logic             in_fcs;
    logic             fcs_en;
    logic [1:0]       fcs_sel;
    logic [31:0]      fcs;
    byte_t            frame_byte;
    byte_t            fcs_byte;
    byte_t            out_byte;

    //////////////////////////////
    // byte position decode
    //////////////////////////////

    assign pay_end  = LEN_W'(HDR_LEN) + len_q;
    assign last_idx = pay_end + LEN_W'(FCS_LEN - 1);

    assign in_payload = active && (idx >= HDR_LEN) && (idx < pay_end);
    assign in_fcs     = active && (idx >= pay_end);
    assign fcs_en     = active && (idx >= FCS_START_IDX) && (idx < pay_end);

    assign o_rd       = in_payload;
    assign o_byte_idx = idx;

    // idle cycles seen between the last and the next valid byte
    assign gap_done = ({1'b0, gap_cnt} + 9'd1) >= {1'b0, i_ipg};
    assign start    = !o_busy && i_frame_stored && gap_done && i_mac_ready;

    //////////////////////////////
    // output byte mux
    //////////////////////////////

    assign frame_byte = (idx < HDR_LEN) ? i_hdr_byte : i_rd_data;

    // fcs goes out lsb byte first and mcrc flips the upper half
    assign fcs_sel = idx[1:0] - pay_end[1:0];

    always_comb
    begin
        fcs_byte = fcs[fcs_sel*8 +: 8];
        if (!fcs_mode_q && fcs_sel[1])
        begin
            fcs_byte = ~fcs_byte;
        end
    end

    assign out_byte = in_fcs ? fcs_byte : frame_byte;

    mac_tx_fcs u_fcs (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_fcs_clear (start),
        .i_fcs_en    (fcs_en),
        .i_data      (frame_byte),
        .o_fcs       (fcs)
    );

    //////////////////////////////
    // sequencer and counters
    //////////////////////////////

    // byte 0 goes out on the start edge so the index runs one ahead
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            active         <= 1'b0;
            idx            <= '0;
            len_q          <= '0;
            fcs_mode_q     <= 1'b0;
            o_tx           <= '0;
            o_frames_cnt   <= '0;
            o_fragment_cnt <= '0;
        end
        else
        begin
            o_tx.data  <= out_byte;
            o_tx.valid <= start || active;
            o_tx.last  <= active && (idx == last_idx);

            if (start)
            begin
                active       <= 1'b1;
                idx          <= LEN_W'(1);
                // held here since the next payload may land during the fcs
                len_q        <= i_payload_len;
                fcs_mode_q   <= i_hdr.fcs_mode;
                o_frames_cnt <= o_frames_cnt + 1'b1;
                if (i_hdr.preempt)
                begin
                    o_fragment_cnt <= o_fragment_cnt + 1'b1;
                end
            end
            else if (active)
            begin
                if (idx == last_idx)
                begin
                    active <= 1'b0;
                    idx    <= '0;
                end
                else
                begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // saturating inter packet gap counter
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            gap_cnt <= '0;
        end
        else if (o_tx.valid)
        begin
            gap_cnt <= '0;
        end
        else if (gap_cnt != 8'hFF)
        begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    assign o_busy = active || o_tx.valid;

endmodule

//--- verilog/mac_tx_header_regs.sv
`timescale 1ns/100ps

module mac_tx_header_regs
    import mac_tx_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  mac_addr_t        i_dst_mac,
    input  logic             i_dst_mac_valid,
    input  mac_addr_t        i_src_mac,
    input  logic             i_src_mac_valid,
    input  byte_t            i_smd,
    input  logic             i_smd_valid,
    input  byte_t            i_fra,
    input  logic             i_fra_valid,
    input  byte_t            i_ipg,
    input  logic             i_ipg_valid,
    input  logic [15:0]      i_send_type,
    input  logic             i_fcs_mode,
    input  logic             i_send_valid,
    input  logic             i_send_last,
    input  logic [LEN_W-1:0] i_byte_idx,
    output frame_hdr_t       o_hdr,
    output byte_t            o_hdr_byte,
    output byte_t            o_ipg
);

    mac_addr_t               dst_q;
    mac_addr_t               src_q;
    logic [15:0]             type_q;
    byte_t                   smd_q;
    byte_t                   fra_q;
    logic                    fcs_mode_q;
    logic                    in_pkt;
    logic                    preempt;
    logic [HDR_LEN*8-1:0]    hdr_vec;
    logic [4:0]              hdr_lane;

    //////////////////////////////
    // settings registers
    //////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            dst_q      <= DEFAULT_DST_MAC;
            src_q      <= DEFAULT_SRC_MAC;
            type_q     <= '0;
            smd_q      <= '0;
            fra_q      <= '0;
            fcs_mode_q <= 1'b1;
            o_ipg      <= DEFAULT_IPG;
            in_pkt     <= 1'b0;
        end
        else
        begin
            if (i_dst_mac_valid) dst_q <= i_dst_mac;
            if (i_src_mac_valid) src_q <= i_src_mac;
            if (i_smd_valid)     smd_q <= i_smd;
            if (i_fra_valid)     fra_q <= i_fra;
            if (i_ipg_valid)     o_ipg <= i_ipg;

            // type rides on the first byte, crc mode on the last
            if (i_send_valid && !in_pkt)
            begin
                type_q <= i_send_type;
            end
            if (i_send_valid && i_send_last)
            begin
                fcs_mode_q <= i_fcs_mode;
                in_pkt     <= 1'b0;
            end
            else if (i_send_valid)
            begin
                in_pkt <= 1'b1;
            end
        end
    end

    // smd-c marks a preemption continuation fragment
    assign preempt = smd_q inside {SMD_C0, SMD_C1, SMD_C2, SMD_C3};

    always_comb
    begin
        o_hdr.dst_mac  = (type_q == ETH_TYPE_ARP) ? '1 : dst_q;
        o_hdr.src_mac  = src_q;
        o_hdr.eth_type = type_q;
        o_hdr.smd      = smd_q;
        o_hdr.fra      = fra_q;
        o_hdr.fcs_mode = fcs_mode_q;
        o_hdr.preempt  = preempt;
    end

    //////////////////////////////
    // header byte lookup
    //////////////////////////////

    // byte 0 sits in the top lane
    assign hdr_vec = {{PREAMBLE_LEN{PREAMBLE_BYTE}},
                      preempt ? smd_q : PREAMBLE_BYTE,
                      preempt ? fra_q : smd_q,
                      o_hdr.dst_mac,
                      src_q,
                      type_q};

    assign hdr_lane   = 5'(HDR_LEN - 1) - i_byte_idx[4:0];
    assign o_hdr_byte = (i_byte_idx < HDR_LEN) ? hdr_vec[hdr_lane*8 +: 8] : '0;

endmodule

//--- verilog/mac_tx_payload_buffer.sv
`timescale 1ns/100ps

module mac_tx_payload_buffer
    import mac_tx_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  byte_t            i_send_data,
    input  logic             i_send_valid,
    input  logic             i_send_last,
    input  logic             i_rd,
    output byte_t            o_rd_data,
    output logic             o_frame_stored,
    output logic [LEN_W-1:0] o_payload_len,
    output logic             o_send_ready
);

    byte_t            mem [PAYLOAD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LEN_W-1:0] rd_cnt;
    logic             receiving;
    logic             first_byte;
    logic             accept;
    logic             wr_en;

    // a payload opens only while ready, then runs until its last byte
    assign first_byte = i_send_valid && o_send_ready;
    assign accept     = i_send_valid && (o_send_ready || receiving);
    // bytes past the ethernet maximum are not stored
    assign wr_en      = accept && (first_byte || (o_payload_len < MAX_PAYLOAD));

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= i_send_data;
        end
    end

    // first word fall through
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            rd_cnt         <= '0;
            receiving      <= 1'b0;
            o_frame_stored <= 1'b0;
            o_payload_len  <= '0;
            o_send_ready   <= 1'b1;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr        <= wr_ptr + 1'b1;
                o_payload_len <= first_byte ? LEN_W'(1) : o_payload_len + 1'b1;
            end

            if (accept && i_send_last)
            begin
                receiving      <= 1'b0;
                o_frame_stored <= 1'b1;
            end
            else if (first_byte)
            begin
                receiving <= 1'b1;
            end
            else if (i_rd)
            begin
                o_frame_stored <= 1'b0;
            end

            // ready comes back once the framer has drained the payload
            if (first_byte)
            begin
                o_send_ready <= 1'b0;
            end
            else if (i_rd && (rd_cnt == o_payload_len - 1'b1))
            begin
                o_send_ready <= 1'b1;
            end

            if (i_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_cnt <= (rd_cnt == o_payload_len - 1'b1) ? '0 : rd_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/mac_tx_fcs.sv
`timescale 1ns/100ps

module mac_tx_fcs
    import mac_tx_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_fcs_clear,
    input  logic        i_fcs_en,
    input  byte_t       i_data,
    output logic [31:0] o_fcs
);

    // reflected form of 0x04C11DB7
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;

    logic [31:0] crc_q;

    // one byte through the lsb-first crc, bit by bit
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++)
        begin
            if (c[0])
            begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end
            else
            begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            crc_q <= '1;
        end
        else if (i_fcs_clear)
        begin
            crc_q <= '1;
        end
        else if (i_fcs_en)
        begin
            crc_q <= crc_byte(crc_q, i_data);
        end
    end

    // final inversion, byte 0 goes on the wire first
    assign o_fcs = ~crc_q;

endmodule

//--- verilog/mac_tx_pkg.sv
package mac_tx_pkg;

    //////////////////////////////
    // basic types
    //////////////////////////////

    typedef logic [47:0] mac_addr_t;
    typedef logic [7:0]  byte_t;

    //////////////////////////////
    // frame layout
    //////////////////////////////

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam int    PREAMBLE_LEN  = 6;
    // payload starts right after preamble, smd, two macs and type
    localparam int    HDR_LEN       = 22;
    localparam int    FCS_LEN       = 4;
    // crc coverage begins at the destination mac
    localparam int    FCS_START_IDX = 8;

    // preemption continuation smds
    localparam byte_t SMD_C0 = 8'h61;
    localparam byte_t SMD_C1 = 8'h52;
    localparam byte_t SMD_C2 = 8'h9E;
    localparam byte_t SMD_C3 = 8'h2A;

    localparam logic [15:0] ETH_TYPE_ARP    = 16'h0806;
    localparam mac_addr_t   DEFAULT_DST_MAC = 48'h00_00_00_FF_FF_FF;
    localparam mac_addr_t   DEFAULT_SRC_MAC = 48'hFF_FF_FF_00_00_00;
    localparam byte_t       DEFAULT_IPG     = 8'd12;

    // payload storage
    localparam int MAX_PAYLOAD   = 1500;
    localparam int PAYLOAD_DEPTH = 2048;
    localparam int PTR_W         = $clog2(PAYLOAD_DEPTH);
    localparam int LEN_W         = 16;

    //////////////////////////////
    // structs
    //////////////////////////////

    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] eth_type;
        byte_t       smd;
        byte_t       fra;
        logic        fcs_mode;
        logic        preempt;
    } frame_hdr_t;

    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  last;
    } tx_byte_t;

endpackage
